/* verilog/hash_pkg.sv */
package hash_pkg;

  localparam int word_w = 8;

  typedef logic [word_w-1:0] hash_word_t;
  typedef logic [31:0] nonce_t;
  typedef logic [12*word_w-1:0] header_t;
  typedef logic [word_w-1:0] target_t;
  typedef logic [4:0] round_t;

  // Nonce in the low bytes, so word n is byte n from the bottom
  typedef struct packed {
    header_t header;
    nonce_t  nonce;
  } message_t;

  typedef struct packed {
    hash_word_t c;
    hash_word_t b;
    hash_word_t a;
  } digest_t;

  typedef enum logic [1:0] {
    idle,
    launch,
    wait_hash,
    finish
  } search_state_t;

  localparam int msg_words = 16;
  localparam int num_rounds = 32;

  // Round where k and the x rule change over
  localparam round_t k_switch_round = 5'd16;

  localparam hash_word_t k_early = 8'h99;
  localparam hash_word_t k_late = 8'ha1;

  localparam digest_t iv_digest = '{c: 8'hfe, b: 8'h89, a: 8'h01};

endpackage

/* verilog/search_ctrl.sv */
`timescale 1ns/1ps

module search_ctrl #(
  parameter hash_pkg::nonce_t max_nonce = 32'd255
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  hash_pkg::header_t  header,
  input  hash_pkg::target_t  target,
  input  logic               hash_valid,
  input  hash_pkg::digest_t  digest,
  output logic               hash_start,
  output hash_pkg::message_t message,
  output logic               busy,
  output logic               done,
  output logic               found,
  output hash_pkg::nonce_t   nonce_out
);
  import hash_pkg::*;

  search_state_t state;
  header_t       header_q;
  target_t       target_q;
  nonce_t        nonce;

  logic accept_start;
  logic hit;
  logic last_nonce;

  // Start only counts when no search is running
  assign accept_start = start && ((state == idle) || (state == finish));

  // Both middle and high digest bytes must be under the target
  assign hit = (digest.c < target_q) && (digest.b < target_q);
  assign last_nonce = (nonce == max_nonce);

  assign hash_start = (state == launch);
  assign busy = (state == launch) || (state == wait_hash);
  assign done = (state == finish);

  assign message.header = header_q;
  assign message.nonce = nonce;

  // Search inputs captured with the start strobe
  always_ff @(posedge clk) begin
    if (accept_start) begin
      header_q <= header;
      target_q <= target;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= idle;
      nonce <= '0;
      found <= 1'b0;
      nonce_out <= '0;
    end else begin
      case (state)
        idle: begin
          if (accept_start) begin
            nonce <= '0;
            state <= launch;
          end
        end
        launch: begin
          state <= wait_hash;
        end
        wait_hash: begin
          if (hash_valid) begin
            if (hit) begin
              found <= 1'b1;
              nonce_out <= nonce;
              state <= finish;
            end else if (last_nonce) begin
              found <= 1'b0;
              nonce_out <= '0;
              state <= finish;
            end else begin
              nonce <= nonce + 1'b1;
              state <= launch;
            end
          end
        end
        finish: begin
          // Result held until the next search begins
          if (accept_start) begin
            nonce <= '0;
            found <= 1'b0;
            nonce_out <= '0;
            state <= launch;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

/* verilog/msg_schedule.sv */
`timescale 1ns/1ps

module msg_schedule (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 hash_start,
  input  hash_pkg::message_t   message,
  input  logic                 word_advance,
  output hash_pkg::hash_word_t round_word
);
  import hash_pkg::*;

  // Entry 0 is the word for the current round
  hash_word_t [msg_words-1:0] window;
  hash_word_t                 new_word;

  // W[i] = W[i-3] | (W[i-9] ^ W[i-14]), seen from the window head
  assign new_word = window[13] | (window[7] ^ window[2]);

  assign round_word = window[0];

  always_ff @(posedge clk) begin
    if (!reset) begin
      window <= '0;
    end else if (hash_start) begin
      for (int i = 0; i < msg_words; i++) begin
        window[i] <= message[i*word_w +: word_w];
      end
    end else if (word_advance) begin
      for (int i = 0; i < msg_words - 1; i++) begin
        window[i] <= window[i+1];
      end
      window[msg_words-1] <= new_word;
    end
  end

endmodule

/* verilog/hash_rounds.sv */
`timescale 1ns/1ps

module hash_rounds (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 hash_start,
  input  hash_pkg::hash_word_t round_word,
  output logic                 word_advance,
  output hash_pkg::digest_t    digest,
  output logic                 hash_valid
);
  import hash_pkg::*;

  localparam round_t last_round = round_t'(num_rounds - 1);

  hash_word_t a;
  hash_word_t b;
  hash_word_t c;
  hash_word_t x;
  hash_word_t k;

  logic   running;
  logic   phase;
  logic   final_add;
  logic   late;
  round_t round;

  assign late = (round >= k_switch_round);

  // Second phase closes the round and consumes the word
  assign word_advance = running && phase;

  always_ff @(posedge clk) begin
    if (!reset) begin
      running <= 1'b0;
      phase <= 1'b0;
      round <= '0;
      final_add <= 1'b0;
      hash_valid <= 1'b0;
    end else begin
      hash_valid <= final_add && !hash_start;
      final_add <= 1'b0;
      if (hash_start) begin
        running <= 1'b1;
        phase <= 1'b0;
        round <= '0;
      end else if (running) begin
        phase <= ~phase;
        if (phase) begin
          if (round == last_round) begin
            running <= 1'b0;
            final_add <= 1'b1;
          end else begin
            round <= round + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hash_start) begin
      a <= iv_digest.a;
      b <= iv_digest.b;
      c <= iv_digest.c;
      k <= k_early;
    end else if (running && !phase) begin
      // x switches from XOR to OR together with k
      x <= late ? (a | b) : (a ^ b);
      a <= b ^ c;
      b <= c << 4;
      if (late) begin
        k <= k_late;
      end
    end else if (running) begin
      c <= x + k + round_word;
    end else if (final_add) begin
      digest.a <= iv_digest.a + a;
      digest.b <= iv_digest.b + b;
      digest.c <= iv_digest.c + c;
    end
  end

endmodule

/* verilog/nonce_search_top.sv */
`timescale 1ns/1ps

module nonce_search_top #(
  parameter hash_pkg::nonce_t max_nonce = 32'd255
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  hash_pkg::header_t header,
  input  hash_pkg::target_t target,
  output logic              busy,
  output logic              done,
  output logic              found,
  output hash_pkg::nonce_t  nonce_out
);
  import hash_pkg::*;

  logic       hash_start;
  logic       word_advance;
  logic       hash_valid;
  message_t   message;
  hash_word_t round_word;
  digest_t    digest;

  search_ctrl #(
    .max_nonce(max_nonce)
  ) ctrl0 (
    .clk(clk),
    .reset(reset),
    .start(start),
    .header(header),
    .target(target),
    .hash_valid(hash_valid),
    .digest(digest),
    .hash_start(hash_start),
    .message(message),
    .busy(busy),
    .done(done),
    .found(found),
    .nonce_out(nonce_out)
  );

  msg_schedule sched0 (
    .clk(clk),
    .reset(reset),
    .hash_start(hash_start),
    .message(message),
    .word_advance(word_advance),
    .round_word(round_word)
  );

  hash_rounds rounds0 (
    .clk(clk),
    .reset(reset),
    .hash_start(hash_start),
    .round_word(round_word),
    .word_advance(word_advance),
    .digest(digest),
    .hash_valid(hash_valid)
  );

endmodule

/* include/hash_ref.svh */
`ifndef HASH_REF_SVH
`define HASH_REF_SVH

// Digest of one attempt, returned as {c, b, a}
function automatic logic [23:0] ref_digest(input logic [95:0] hdr,
                                           input logic [31:0] nonce);
  logic [7:0] w [0:31];
  logic [7:0] a;
  logic [7:0] b;
  logic [7:0] c;
  logic [7:0] x;
  logic [7:0] k;
  logic [7:0] a_next;
  // Nonce bytes first, low byte first, then the header bytes
  for (int i = 0; i < 4; i++) begin
    w[i] = nonce[8*i +: 8];
  end
  for (int i = 0; i < 12; i++) begin
    w[4+i] = hdr[8*i +: 8];
  end
  for (int i = 16; i < 32; i++) begin
    w[i] = w[i-3] | (w[i-9] ^ w[i-14]);
  end
  a = 8'h01;
  b = 8'h89;
  c = 8'hfe;
  for (int r = 0; r < 32; r++) begin
    if (r < 16) begin
      x = a ^ b;
      k = 8'h99;
    end else begin
      x = a | b;
      k = 8'ha1;
    end
    a_next = b ^ c;
    b = c << 4;
    a = a_next;
    c = x + k + w[r];
  end
  return {8'hfe + c, 8'h89 + b, 8'h01 + a};
endfunction

// First nonce from zero up to limit whose c and b bytes are under the target,
// returned as {found, nonce}
function automatic logic [32:0] ref_search(input logic [95:0] hdr,
                                           input logic [7:0] tgt,
                                           input logic [31:0] limit);
  logic [23:0] d;
  logic [32:0] result;
  logic        hit;
  result = {1'b0, 32'd0};
  hit = 1'b0;
  for (longint i = 0; (i <= longint'(limit)) && !hit; i++) begin
    d = ref_digest(hdr, i[31:0]);
    if ((d[23:16] < tgt) && (d[15:8] < tgt)) begin
      hit = 1'b1;
      result = {1'b1, i[31:0]};
    end
  end
  return result;
endfunction

`endif

/* test/tb_nonce_search.sv */
`timescale 1ns/1ps

module tb_nonce_search;
  import hash_pkg::*;

  `include "hash_ref.svh"

  localparam nonce_t max_nonce = 32'd63;
  localparam int clk_period = 100;
  localparam int attempt_cycles = 67;
  localparam int search_bound = 64 * 67 + 10;
  localparam int watchdog_cycles = 8 * 64 * 67 + 1000;

  logic    clk;
  logic    reset;
  logic    start;
  header_t header;
  target_t target;
  logic    busy;
  logic    done;
  logic    found;
  nonce_t  nonce_out;

  int seed;
  int errors;
  int tests;

  nonce_search_top #(
    .max_nonce(max_nonce)
  ) dut0 (
    .clk(clk),
    .reset(reset),
    .start(start),
    .header(header),
    .target(target),
    .busy(busy),
    .done(done),
    .found(found),
    .nonce_out(nonce_out)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic pulse_start(input header_t hdr, input target_t tgt);
    @(negedge clk);
    start = 1'b1;
    header = hdr;
    target = tgt;
    @(negedge clk);
    start = 1'b0;
  endtask

  // Polls done on falling edges until it rises or the bound runs out
  task automatic wait_done(output logic ended);
    int cycles;
    cycles = 0;
    ended = done;
    while (!ended && (cycles < search_bound)) begin
      @(negedge clk);
      cycles++;
      ended = done;
    end
    if (!ended) begin
      $display("Search did not finish within %0d cycles at %0t ns", search_bound, $time);
      errors++;
    end
  endtask

  task automatic search_and_check(input header_t hdr, input target_t tgt);
    logic        ended;
    logic [32:0] expected;
    int          attempts;
    time         t_start;
    pulse_start(hdr, tgt);
    t_start = $time;
    check_value("done", 32'd0, {31'd0, done});
    check_value("busy", 32'd1, {31'd0, busy});
    wait_done(ended);
    expected = ref_search(hdr, tgt, max_nonce);
    if (expected[32]) begin
      attempts = expected[31:0] + 1;
    end else begin
      attempts = max_nonce + 1;
    end
    if (ended) begin
      check_value("busy", 32'd0, {31'd0, busy});
      check_value("found", {31'd0, expected[32]}, {31'd0, found});
      check_value("nonce_out", expected[31:0], nonce_out);
      // Each nonce tried costs one full attempt
      check_value("done latency", attempts * attempt_cycles, ($time - t_start) / clk_period);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset_state();
    int errors_before;
    errors_before = errors;
    @(negedge clk);
    check_value("busy", 32'd0, {31'd0, busy});
    check_value("done", 32'd0, {31'd0, done});
    check_value("found", 32'd0, {31'd0, found});
    check_value("nonce_out", 32'd0, nonce_out);
    report_test("reset state", errors_before);
  endtask

  task automatic test_loose_target();
    int errors_before;
    errors_before = errors;
    search_and_check(96'h0123_4567_89ab_cdef_0011_2233, 8'hff);
    report_test("loose target", errors_before);
  endtask

  task automatic test_random_headers();
    int      errors_before;
    header_t hdr;
    errors_before = errors;
    for (int i = 0; i < 3; i++) begin
      hdr = {$random(seed), $random(seed), $random(seed)};
      search_and_check(hdr, 8'h40);
    end
    report_test("random headers", errors_before);
  endtask

  task automatic test_zero_target();
    int errors_before;
    errors_before = errors;
    // Nothing can be under zero, so only the nonce limit ends this search
    search_and_check(96'hfeed_0000_1234_5678_9abc_def0, 8'h00);
    report_test("zero target", errors_before);
  endtask

  task automatic test_start_while_busy();
    int          errors_before;
    logic        ended;
    logic [32:0] expected;
    header_t     first_hdr;
    header_t     second_hdr;
    errors_before = errors;
    first_hdr = {$random(seed), $random(seed), $random(seed)};
    second_hdr = ~first_hdr;
    pulse_start(first_hdr, 8'h40);
    repeat (10) @(negedge clk);
    check_value("busy", 32'd1, {31'd0, busy});
    pulse_start(second_hdr, 8'h00);
    wait_done(ended);
    expected = ref_search(first_hdr, 8'h40, max_nonce);
    if (ended) begin
      check_value("found", {31'd0, expected[32]}, {31'd0, found});
      check_value("nonce_out", expected[31:0], nonce_out);
    end
    // New search from finish
    search_and_check(second_hdr, 8'h80);
    report_test("start while busy", errors_before);
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired before the tests finished at %0t ns", $time);
    $display("sim failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    reset = 1'b0;
    start = 1'b0;
    header = '0;
    target = '0;
    seed = 35345;
    errors = 0;
    tests = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;

    test_reset_state();
    test_loose_target();
    test_random_headers();
    test_zero_target();
    test_start_while_busy();

    $display("Tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
verilog/hash_pkg.sv
verilog/search_ctrl.sv
verilog/msg_schedule.sv
verilog/hash_rounds.sv
verilog/nonce_search_top.sv
test/tb_nonce_search.sv

/* Makefile */
# Verilator simulation of the nonce search testbench

VERILATOR ?= verilator
TOP ?= tb_nonce_search
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
